// ==== dv/save_sequencer_chk.sv ====
`timescale 1ns/100ps

module save_sequencer_chk
(
	input  logic                  clk_sys,
	input  logic                  nRESET,
	input  logic                  sd_rd,
	input  logic                  sd_wr,
	input  logic                  sd_ack,
	input  logic                  lba_step,
	input  logic                  last_sector,
	input  save_pkg::seq_state_t  state
);

	// ========================================
	// Request protocol
	// ========================================

	// One direction at a time
	a_one_direction: assert property (@(posedge clk_sys) disable iff (!nRESET)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr high together");

	// A new request only after the image side has released sd_ack
	a_no_rise_in_ack: assert property (@(posedge clk_sys) disable iff (!nRESET)
		sd_ack |-> !$rose(sd_rd) && !$rose(sd_wr))
		else $error("request rose while sd_ack was high");

	// The final sector neither advances the LBA nor requests again
	a_no_step_at_end: assert property (@(posedge clk_sys) disable iff (!nRESET)
		$fell(sd_ack) && last_sector |=>
			!$past(lba_step) && !sd_rd && !sd_wr && state == save_pkg::st_idle)
		else $error("step or new request after the last sector");

	// Quiet and idle while held in reset
	a_reset_quiet: assert property (@(posedge clk_sys)
		!nRESET |-> !sd_rd && !sd_wr && state == save_pkg::st_idle)
		else $error("request or active state during reset");

endmodule

bind save_sequencer save_sequencer_chk chk_i
(
	.clk_sys(clk_sys), .nRESET(nRESET), .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_ack(sd_ack),
	.lba_step(lba_step), .last_sector(last_sector), .state(state)
);

// ==== dv/save_store_tb.sv ====
`timescale 1ns/100ps

module save_store_tb;

	localparam int BACKUP_SECTORS = 128;
	localparam int CARD_SECTORS = 16;
	localparam int CART_CARD_SECTORS = 4;
	localparam int CART_SECTORS = BACKUP_SECTORS + CART_CARD_SECTORS;
	localparam int WORDS = save_pkg::SECTOR_WORDS;
	localparam int BK_WORDS = BACKUP_SECTORS * WORDS;
	localparam int CARD_WORDS = CARD_SECTORS * WORDS;
	localparam int BK_ADDR_BITS = 15;
	localparam int CARD_ADDR_BITS = 13;
	// A request follows its trigger within two cycles
	localparam int REQ_TIMEOUT = 2;
	// Request, ack delay, 256 words and the ack release, rounded up
	localparam int SECTOR_CYCLES = 300;
	localparam int WATCHDOG_CYCLES = 3 * CART_SECTORS * SECTOR_CYCLES + 20000;

	logic clk_sys;
	logic nRESET;
	save_pkg::system_type_t system_type;
	logic ioctl_download;
	logic img_mounted;
	logic img_readonly;
	logic [63:0] img_size;
	logic save_req;
	logic sd_ack;
	save_pkg::sector_word_t sd_buff_addr;
	save_pkg::sd_word_t sd_buff_dout;
	logic sd_buff_wr;
	logic sd_rd;
	logic sd_wr;
	save_pkg::lba_t sd_lba;
	save_pkg::sd_word_t sd_buff_din;
	logic [BK_ADDR_BITS-1:0] bk_addr;
	save_pkg::sd_word_t bk_wdata;
	logic bk_we_lo;
	logic bk_we_hi;
	save_pkg::sd_word_t bk_rdata;
	logic [CARD_ADDR_BITS-1:0] card_addr;
	save_pkg::host_byte_t card_wdata;
	logic card_we;
	save_pkg::host_byte_t card_rdata;

	// Image model and shadow copies of both RAMs
	save_pkg::sd_word_t image_words [CART_SECTORS*WORDS];
	save_pkg::sd_word_t bk_shadow [BK_WORDS];
	save_pkg::sd_word_t card_shadow [CARD_WORDS];

	logic [31:0] lfsr_state;
	int value_errors;
	int other_errors;

	save_store #(.BACKUP_SECTORS(BACKUP_SECTORS), .CARD_SECTORS(CARD_SECTORS),
		.CART_CARD_SECTORS(CART_CARD_SECTORS)) dut_i
	(
		.clk_sys(clk_sys), .nRESET(nRESET), .system_type(system_type),
		.ioctl_download(ioctl_download), .img_mounted(img_mounted),
		.img_readonly(img_readonly), .img_size(img_size), .save_req(save_req),
		.sd_ack(sd_ack), .sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout),
		.sd_buff_wr(sd_buff_wr), .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_lba(sd_lba),
		.sd_buff_din(sd_buff_din), .bk_addr(bk_addr), .bk_wdata(bk_wdata),
		.bk_we_lo(bk_we_lo), .bk_we_hi(bk_we_hi), .bk_rdata(bk_rdata),
		.card_addr(card_addr), .card_wdata(card_wdata), .card_we(card_we),
		.card_rdata(card_rdata)
	);

	initial
	begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired before all tests finished");
		$display("Simulation failed");
		$finish;
	end

	// ========================================
	// Helpers
	// ========================================

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int b = 0; b < n; b++)
		begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	function automatic bit cd_mode();
		return system_type == save_pkg::sys_cd || system_type == save_pkg::sys_cdz;
	endfunction

	// Word the image side should read back during a save
	function automatic save_pkg::sd_word_t save_word(input int lba, input int i);
		if (cd_mode())
			return card_shadow[lba*WORDS + i];
		else if (lba < BACKUP_SECTORS)
			return bk_shadow[lba*WORDS + i];
		return card_shadow[(lba - BACKUP_SECTORS)*WORDS + i];
	endfunction

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic fill_image();
		for (int k = 0; k < CART_SECTORS*WORDS; k++)
			image_words[k] = save_pkg::sd_word_t'(rand_bits(16));
	endtask

	task automatic check_quiet(input int cycles);
		for (int c = 0; c < cycles; c++)
		begin
			next_cycle();
			assert (!sd_rd && !sd_wr) else
			begin
				other_errors++;
				$display("Unexpected sector request at LBA %0d", sd_lba);
			end
		end
	endtask

	// Download end queues a load
	task automatic pulse_download();
		ioctl_download = 1'b1;
		repeat (3) next_cycle();
		ioctl_download = 1'b0;
		repeat (2) next_cycle();
	endtask

	// Mount pulse arms the sequencer
	task automatic mount_image(input logic readonly);
		img_readonly = readonly;
		img_mounted = 1'b1;
		next_cycle();
		img_mounted = 1'b0;
	endtask

	// ========================================
	// Image side model
	// ========================================

	task automatic serve_sector(input bit load, input int lba);
		save_pkg::sd_word_t w;
		repeat (2) next_cycle();
		sd_ack = 1'b1;
		next_cycle();
		assert (!sd_rd && !sd_wr) else
		begin
			other_errors++;
			$display("Request still high after sd_ack rose at LBA %0d", lba);
		end
		for (int i = 0; i < WORDS; i++)
		begin
			sd_buff_addr = save_pkg::sector_word_t'(i);
			if (load)
			begin
				w = image_words[lba*WORDS + i];
				sd_buff_dout = w;
				sd_buff_wr = 1'b1;
				// Shadow follows the layout of the image
				if (cd_mode())
					card_shadow[lba*WORDS + i] = w;
				else if (lba >= BACKUP_SECTORS)
					card_shadow[(lba - BACKUP_SECTORS)*WORDS + i] = w;
				else if (system_type == save_pkg::sys_arcade)
					bk_shadow[lba*WORDS + i] = w;
				next_cycle();
			end
			else
			begin
				// Read data one clock after the address
				next_cycle();
				assert (sd_buff_din === save_word(lba, i)) else
				begin
					value_errors++;
					$display("FAILED sd_buff_din: LBA %h word %h got %h expected %h",
						lba, i, sd_buff_din, save_word(lba, i));
				end
			end
		end
		sd_buff_wr = 1'b0;
		sd_ack = 1'b0;
		next_cycle();
	endtask

	task automatic run_transfer(input bit load, input int sectors);
		int waited;
		for (int s = 0; s < sectors; s++)
		begin
			waited = 0;
			while (!sd_rd && !sd_wr && waited < REQ_TIMEOUT)
			begin
				next_cycle();
				waited++;
			end
			assert (sd_rd || sd_wr) else
			begin
				other_errors++;
				$display("No request for sector %0d within %0d cycles", s, REQ_TIMEOUT);
				return;
			end
			assert (sd_lba === save_pkg::lba_t'(s)) else
			begin
				value_errors++;
				$display("FAILED sd_lba: got %h expected %h", sd_lba, s);
			end
			assert (sd_rd === load && sd_wr === !load) else
			begin
				value_errors++;
				$display("FAILED sd_rd/sd_wr: got %h/%h expected %h/%h", sd_rd, sd_wr,
					load, !load);
			end
			serve_sector(load, s);
		end
		// Nothing follows the last sector
		check_quiet(16);
	endtask

	task automatic run_save(input int sectors);
		save_req = 1'b1;
		run_transfer(1'b0, sectors);
		save_req = 1'b0;
		next_cycle();
	endtask

	// ========================================
	// Host port
	// ========================================

	task automatic check_host_reads(input int count, input int card_bytes);
		save_pkg::sd_word_t exp_word;
		save_pkg::host_byte_t exp_byte;
		int a;
		for (int k = 0; k < count; k++)
		begin
			bk_addr = BK_ADDR_BITS'(rand_bits(BK_ADDR_BITS));
			next_cycle();
			exp_word = (system_type == save_pkg::sys_arcade) ? bk_shadow[bk_addr] : '0;
			assert (bk_rdata === exp_word) else
			begin
				value_errors++;
				$display("FAILED bk_rdata: addr %h got %h expected %h", bk_addr, bk_rdata,
					exp_word);
			end
			a = int'(rand_bits(CARD_ADDR_BITS)) % card_bytes;
			card_addr = CARD_ADDR_BITS'(a);
			next_cycle();
			exp_byte = (a % 2 == 1) ? card_shadow[a/2][15:8] : card_shadow[a/2][7:0];
			assert (card_rdata === exp_byte) else
			begin
				value_errors++;
				$display("FAILED card_rdata: addr %h got %h expected %h", a, card_rdata,
					exp_byte);
			end
		end
	endtask

	// Single lane backup writes and card byte writes inside the cartridge card
	task automatic random_host_writes(input int count);
		logic lane;
		int a;
		for (int k = 0; k < count; k++)
		begin
			lane = 1'(rand_bits(1));
			bk_addr = BK_ADDR_BITS'(rand_bits(BK_ADDR_BITS));
			bk_wdata = save_pkg::sd_word_t'(rand_bits(16));
			bk_we_lo = ~lane;
			bk_we_hi = lane;
			if (lane)
				bk_shadow[bk_addr][15:8] = bk_wdata[15:8];
			else
				bk_shadow[bk_addr][7:0] = bk_wdata[7:0];
			a = int'(rand_bits(11));
			card_addr = CARD_ADDR_BITS'(a);
			card_wdata = save_pkg::host_byte_t'(rand_bits(8));
			card_we = 1'b1;
			if (a % 2 == 1)
				card_shadow[a/2][15:8] = card_wdata;
			else
				card_shadow[a/2][7:0] = card_wdata;
			next_cycle();
			bk_we_lo = 1'b0;
			bk_we_hi = 1'b0;
			card_we = 1'b0;
		end
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial
	begin
		lfsr_state = 32'd44;
		value_errors = 0;
		other_errors = 0;
		nRESET = 1'b0;
		system_type = save_pkg::sys_arcade;
		ioctl_download = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = 64'd67584;
		save_req = 1'b0;
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
		bk_addr = '0;
		bk_wdata = '0;
		bk_we_lo = 1'b0;
		bk_we_hi = 1'b0;
		card_addr = '0;
		card_wdata = '0;
		card_we = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1;
		nRESET = 1'b1;
		next_cycle();

		// Download end with no image mounted
		pulse_download();
		check_quiet(20);

		// Arcade load of backup plus cartridge card
		fill_image();
		pulse_download();
		mount_image(1'b0);
		run_transfer(1'b1, CART_SECTORS);
		check_host_reads(64, CART_CARD_SECTORS * WORDS * 2);

		// Arcade save after host writes
		random_host_writes(64);
		run_save(CART_SECTORS);

		// Read-only image ignores both triggers
		pulse_download();
		mount_image(1'b1);
		check_quiet(20);
		save_req = 1'b1;
		check_quiet(20);
		save_req = 1'b0;

		// CD layout with the card only
		system_type = save_pkg::sys_cd;
		fill_image();
		pulse_download();
		mount_image(1'b0);
		run_transfer(1'b1, CARD_SECTORS);
		check_host_reads(64, CARD_WORDS * 2);
		run_save(CARD_SECTORS);

		// Console save with the arcade contents still in backup RAM
		system_type = save_pkg::sys_console;
		run_save(CART_SECTORS);
		check_host_reads(32, CARD_WORDS * 2);

		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== files.f ====
logic/save_pkg.sv
logic/save_sequencer.sv
logic/sector_counter.sv
logic/backup_ram.sv
logic/card_ram.sv
logic/save_store.sv
dv/save_sequencer_chk.sv
dv/save_store_tb.sv

// ==== logic/backup_ram.sv ====
`timescale 1ns/100ps

module backup_ram
#(
	parameter int BACKUP_SECTORS = 128,
	localparam int BK_BITS = $clog2(BACKUP_SECTORS),
	localparam int ADDR_BITS = BK_BITS + save_pkg::SECTOR_BITS
)
(
	input  logic                    clk_sys,
	input  save_pkg::system_type_t  system_type,
	input  save_pkg::lba_t          sd_lba,
	input  logic                    sd_ack,
	input  save_pkg::sector_word_t  sd_buff_addr,
	input  save_pkg::sd_word_t      sd_buff_dout,
	input  logic                    sd_buff_wr,
	input  logic [ADDR_BITS-1:0]    host_addr,
	input  save_pkg::sd_word_t      host_wdata,
	input  logic                    host_we_lo,
	input  logic                    host_we_hi,
	output save_pkg::sd_word_t      host_rdata,
	output save_pkg::sd_word_t      sd_rdata
);

	localparam int DEPTH = BACKUP_SECTORS * save_pkg::SECTOR_WORDS;

	save_pkg::sd_word_t mem [0:DEPTH-1];
	save_pkg::sd_word_t host_q;

	logic                 is_mvs;
	logic [ADDR_BITS-1:0] img_addr;
	logic                 img_we;

	// Backup RAM only exists on MVS boards
	assign is_mvs = (system_type == save_pkg::sys_arcade);

	// Low LBA bits pick the sector inside the backup area
	assign img_addr = {sd_lba[BK_BITS-1:0], sd_buff_addr};

	// Only the leading backup sectors of the image land here
	assign img_we = is_mvs & sd_ack & sd_buff_wr & (sd_lba < save_pkg::lba_t'(BACKUP_SECTORS));

	// ========================================
	// Image port and host port
	// ========================================

	always_ff @(posedge clk_sys)
	begin
		if (img_we)
			mem[img_addr] <= sd_buff_dout;
		sd_rdata <= mem[img_addr];

		// Host writes are per byte lane
		if (is_mvs & host_we_lo)
			mem[host_addr][7:0] <= host_wdata[7:0];
		if (is_mvs & host_we_hi)
			mem[host_addr][15:8] <= host_wdata[15:8];
		host_q <= mem[host_addr];
	end

	// Other systems see an empty bus
	assign host_rdata = is_mvs ? host_q : '0;

endmodule

// ==== logic/card_ram.sv ====
`timescale 1ns/100ps

module card_ram
#(
	parameter int BACKUP_SECTORS = 128,
	parameter int CARD_SECTORS = 16,
	localparam int CD_BITS = $clog2(CARD_SECTORS),
	localparam int WORD_BITS = CD_BITS + save_pkg::SECTOR_BITS
)
(
	input  logic                    clk_sys,
	input  save_pkg::system_type_t  system_type,
	input  save_pkg::lba_t          sd_lba,
	input  logic                    sd_ack,
	input  save_pkg::sector_word_t  sd_buff_addr,
	input  save_pkg::sd_word_t      sd_buff_dout,
	input  logic                    sd_buff_wr,
	input  logic [WORD_BITS:0]      host_addr,
	input  save_pkg::host_byte_t    host_wdata,
	input  logic                    host_we,
	output save_pkg::host_byte_t    host_rdata,
	output save_pkg::sd_word_t      sd_rdata
);

	localparam int DEPTH = CARD_SECTORS * save_pkg::SECTOR_WORDS;

	// Even byte in the low half, odd byte in the high half
	save_pkg::sd_word_t mem [0:DEPTH-1];
	save_pkg::sd_word_t host_q;

	logic [WORD_BITS-1:0] img_addr;
	logic [WORD_BITS-1:0] host_word;
	logic                 img_we;
	logic                 host_odd;
	logic                 host_odd_q;

	// Low LBA bits wrap cartridge LBAs 128+ onto card sector 0
	assign img_addr = {sd_lba[CD_BITS-1:0], sd_buff_addr};

	// Card follows the backup area in cartridge images
	assign img_we = sd_ack & sd_buff_wr &
		(save_pkg::is_cd(system_type) | (sd_lba >= save_pkg::lba_t'(BACKUP_SECTORS)));

	assign host_word = host_addr[WORD_BITS:1];
	assign host_odd = host_addr[0];

	// ========================================
	// Image port and host port
	// ========================================

	always_ff @(posedge clk_sys)
	begin
		if (img_we)
			mem[img_addr] <= sd_buff_dout;
		sd_rdata <= mem[img_addr];

		// Single byte write into the addressed half
		if (host_we & host_odd)
			mem[host_word][15:8] <= host_wdata;
		if (host_we & ~host_odd)
			mem[host_word][7:0] <= host_wdata;
		host_q <= mem[host_word];
		host_odd_q <= host_odd;
	end

	// Byte select follows the registered lane bit
	assign host_rdata = host_odd_q ? host_q[15:8] : host_q[7:0];

endmodule

// ==== logic/save_pkg.sv ====
package save_pkg;

	// ========================================
	// Sector geometry
	// ========================================

	// One image sector is 256 words of 16 bits
	localparam int SECTOR_WORDS = 256;
	localparam int SECTOR_BITS = $clog2(SECTOR_WORDS);

	// ========================================
	// Data widths
	// ========================================

	// Word address inside one sector
	typedef logic [SECTOR_BITS-1:0] sector_word_t;

	// Sector number in the save image
	typedef logic [31:0] lba_t;

	// Image side data word
	typedef logic [15:0] sd_word_t;

	// Memory card host byte
	typedef logic [7:0] host_byte_t;

	// System type as selected in the menu, CD and CDZ behave the same here
	typedef enum logic [1:0]
	{
		sys_console = 2'd0,
		sys_arcade  = 2'd1,
		sys_cd      = 2'd2,
		sys_cdz     = 2'd3
	} system_type_t;

	// Save sequencer states
	typedef enum logic
	{
		st_idle   = 1'b0,
		st_active = 1'b1
	} seq_state_t;

	// Both CD flavours share the short card-only image layout
	function automatic logic is_cd(input system_type_t sys);
		return sys inside {sys_cd, sys_cdz};
	endfunction

endpackage

// ==== logic/save_sequencer.sv ====
`timescale 1ns/100ps

module save_sequencer
(
	input  logic        clk_sys,
	input  logic        nRESET,
	input  logic        ioctl_download,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [63:0] img_size,
	input  logic        save_req,
	input  logic        sd_ack,
	input  logic        last_sector,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic        lba_clear,
	output logic        lba_step
);

	save_pkg::seq_state_t state;

	// Previous values for edge detection
	logic download_prev;
	logic save_prev;
	logic ack_prev;

	logic enable;
	logic load_pending;
	// Direction of the running operation, high for a load
	logic loading;

	logic download_rise;
	logic download_fall;
	logic save_rise;
	logic ack_rise;
	logic ack_fall;
	logic image_ok;
	logic start;

	assign download_rise = ioctl_download & ~download_prev;
	assign download_fall = ~ioctl_download & download_prev;
	assign save_rise = save_req & ~save_prev;
	assign ack_rise = sd_ack & ~ack_prev;
	assign ack_fall = ~sd_ack & ack_prev;

	// Mounted, non-empty and writable save image
	assign image_ok = img_mounted & (img_size != 64'd0) & ~img_readonly;

	// Loads win over saves when both are pending
	assign start = (state == save_pkg::st_idle) & enable & (load_pending | save_rise) & ~ack_rise;

	// Counter controls act on the same edge as the request, so sd_lba is valid with it
	assign lba_clear = start;
	assign lba_step = (state == save_pkg::st_active) & ack_fall & ~last_sector;

	// ========================================
	// Arming and triggers
	// ========================================

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			download_prev <= 1'b0;
			save_prev <= 1'b0;
			ack_prev <= 1'b0;
			enable <= 1'b0;
			load_pending <= 1'b0;
		end
		else
		begin
			download_prev <= ioctl_download;
			save_prev <= save_req;
			ack_prev <= sd_ack;

			// New download disarms until the image is seen again
			if (download_rise)
				enable <= 1'b0;
			else if (~ioctl_download & image_ok)
				enable <= 1'b1;

			// Load is queued at download end and consumed at start
			if (download_rise)
				load_pending <= 1'b0;
			else if (download_fall)
				load_pending <= 1'b1;
			else if (start)
				load_pending <= 1'b0;
		end
	end

	// ========================================
	// Sector request FSM
	// ========================================

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			state <= save_pkg::st_idle;
			loading <= 1'b0;
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
		end
		else if (ack_rise)
		begin
			// Image side took the request
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
		end
		else if (state == save_pkg::st_idle)
		begin
			if (start)
			begin
				state <= save_pkg::st_active;
				loading <= load_pending;
				sd_rd <= load_pending;
				sd_wr <= ~load_pending;
			end
		end
		else if (ack_fall)
		begin
			// Sector done, next LBA or stop
			if (last_sector)
				state <= save_pkg::st_idle;
			else
			begin
				sd_rd <= loading;
				sd_wr <= ~loading;
			end
		end
	end

endmodule

// ==== logic/save_store.sv ====
`timescale 1ns/100ps

module save_store
#(
	parameter int BACKUP_SECTORS    = 128,
	parameter int CARD_SECTORS      = 16,
	parameter int CART_CARD_SECTORS = 4,
	localparam int BK_ADDR_BITS = $clog2(BACKUP_SECTORS) + save_pkg::SECTOR_BITS,
	localparam int CARD_ADDR_BITS = $clog2(CARD_SECTORS) + save_pkg::SECTOR_BITS + 1
)
(
	input  logic                       clk_sys,
	input  logic                       nRESET,
	input  save_pkg::system_type_t     system_type,
	input  logic                       ioctl_download,
	input  logic                       img_mounted,
	input  logic                       img_readonly,
	input  logic [63:0]                img_size,
	input  logic                       save_req,
	// Image side
	input  logic                       sd_ack,
	input  save_pkg::sector_word_t     sd_buff_addr,
	input  save_pkg::sd_word_t         sd_buff_dout,
	input  logic                       sd_buff_wr,
	output logic                       sd_rd,
	output logic                       sd_wr,
	output save_pkg::lba_t             sd_lba,
	output save_pkg::sd_word_t         sd_buff_din,
	// Backup RAM host port
	input  logic [BK_ADDR_BITS-1:0]    bk_addr,
	input  save_pkg::sd_word_t         bk_wdata,
	input  logic                       bk_we_lo,
	input  logic                       bk_we_hi,
	output save_pkg::sd_word_t         bk_rdata,
	// Memory card host port
	input  logic [CARD_ADDR_BITS-1:0]  card_addr,
	input  save_pkg::host_byte_t       card_wdata,
	input  logic                       card_we,
	output save_pkg::host_byte_t       card_rdata
);

	logic lba_clear;
	logic lba_step;
	logic last_sector;
	logic card_sel;

	save_pkg::sd_word_t bk_sd_rdata;
	save_pkg::sd_word_t card_sd_rdata;

	save_sequencer seq_i
	(
		.clk_sys(clk_sys), .nRESET(nRESET),
		.ioctl_download(ioctl_download),
		.img_mounted(img_mounted), .img_readonly(img_readonly), .img_size(img_size),
		.save_req(save_req), .sd_ack(sd_ack), .last_sector(last_sector),
		.sd_rd(sd_rd), .sd_wr(sd_wr),
		.lba_clear(lba_clear), .lba_step(lba_step)
	);

	sector_counter #(.BACKUP_SECTORS(BACKUP_SECTORS), .CARD_SECTORS(CARD_SECTORS),
		.CART_CARD_SECTORS(CART_CARD_SECTORS)) cnt_i
	(
		.clk_sys(clk_sys), .nRESET(nRESET), .system_type(system_type),
		.lba_clear(lba_clear), .lba_step(lba_step),
		.sd_lba(sd_lba), .last_sector(last_sector)
	);

	backup_ram #(.BACKUP_SECTORS(BACKUP_SECTORS)) bk_i
	(
		.clk_sys(clk_sys), .system_type(system_type), .sd_lba(sd_lba), .sd_ack(sd_ack),
		.sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout), .sd_buff_wr(sd_buff_wr),
		.host_addr(bk_addr), .host_wdata(bk_wdata),
		.host_we_lo(bk_we_lo), .host_we_hi(bk_we_hi),
		.host_rdata(bk_rdata), .sd_rdata(bk_sd_rdata)
	);

	card_ram #(.BACKUP_SECTORS(BACKUP_SECTORS), .CARD_SECTORS(CARD_SECTORS)) card_i
	(
		.clk_sys(clk_sys), .system_type(system_type), .sd_lba(sd_lba), .sd_ack(sd_ack),
		.sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout), .sd_buff_wr(sd_buff_wr),
		.host_addr(card_addr), .host_wdata(card_wdata), .host_we(card_we),
		.host_rdata(card_rdata), .sd_rdata(card_sd_rdata)
	);

	// Save data source, card on CD or past the backup area
	assign card_sel = save_pkg::is_cd(system_type) |
		(sd_lba >= save_pkg::lba_t'(BACKUP_SECTORS));
	assign sd_buff_din = card_sel ? card_sd_rdata : bk_sd_rdata;

endmodule

// ==== logic/sector_counter.sv ====
`timescale 1ns/100ps

module sector_counter
#(
	parameter int BACKUP_SECTORS    = 128,
	parameter int CARD_SECTORS      = 16,
	parameter int CART_CARD_SECTORS = 4
)
(
	input  logic                    clk_sys,
	input  logic                    nRESET,
	input  save_pkg::system_type_t  system_type,
	input  logic                    lba_clear,
	input  logic                    lba_step,
	output save_pkg::lba_t          sd_lba,
	output logic                    last_sector
);

	// Final LBA of each image layout
	localparam save_pkg::lba_t CD_LAST = save_pkg::lba_t'(CARD_SECTORS - 1);
	localparam save_pkg::lba_t CART_LAST =
		save_pkg::lba_t'(BACKUP_SECTORS + CART_CARD_SECTORS - 1);

	// CD image is card only
	// Cartridge image is backup RAM followed by the card
	assign last_sector = save_pkg::is_cd(system_type) ? (sd_lba == CD_LAST) :
		(sd_lba == CART_LAST);

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
			sd_lba <= '0;
		else if (lba_clear)
			sd_lba <= '0;
		else if (lba_step)
			sd_lba <= sd_lba + save_pkg::lba_t'(1);
	end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module save_store_tb -o save_store_sim

out=$(./obj_dir/save_store_sim)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
	exit 0
fi
exit 1
